// ==== Makefile ====
# Verilator flow for the merge unit: lint, simulate, clean

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module merge_unit -f src.f
	verilator --lint-only --timing --top-module tb_merge_unit -f src.f

sim:
	verilator --binary --timing --top-module tb_merge_unit -Mdir obj_dir -f src.f
	./obj_dir/Vtb_merge_unit > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/merge_pkg.sv ====
// Shared key type and FSM state encodings for the two-run merge unit, referenced by scoped name
`default_nettype none

package merge_pkg;

    // One sort key, compared as unsigned
    typedef logic [15:0] data_t;

    // Loader walks through run A, then run B, then holds until the merge ends
    typedef enum logic [1:0] {
        load_a     = 2'd0,
        load_b     = 2'd1,
        wait_merge = 2'd2
    } loader_state_e;

    typedef enum logic [2:0] {
        idle     = 3'd0,
        merge_ab = 3'd1,
        drain_a  = 3'd2,
        drain_b  = 3'd3
    } merge_state_e;

endpackage

`default_nettype wire

// ==== hw/merge_unit.sv ====
// Top level of the two-run merge unit, taking runs A then B on one stream and emitting their merge
`default_nettype none
`timescale 1ns/1ns

module merge_unit #(
    parameter int MAX_CHUNK = 32
) (
    input  wire                     clock,
    input  wire                     arst_n,
    input  wire merge_pkg::data_t   in_data,
    input  wire                     in_valid,
    input  wire                     in_last,
    output logic                    in_ready,
    output merge_pkg::data_t        out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  wire                     out_ready,
    output logic                    merge_done
);

    localparam int CNT_W = $clog2(MAX_CHUNK) + 1;

    logic             start;
    logic [CNT_W-1:0] size_a;
    logic [CNT_W-1:0] size_b;

    // Loader to FIFO write sides, FIFO read sides to the core
    run_stream_if load_a ();
    run_stream_if load_b ();
    run_stream_if run_a ();
    run_stream_if run_b ();

    run_loader #(
        .MAX_CHUNK (MAX_CHUNK)
    ) i_run_loader (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_ready   (in_ready),
        .load_a     (load_a.source),
        .load_b     (load_b.source),
        .merge_done (merge_done),
        .start      (start),
        .size_a     (size_a),
        .size_b     (size_b)
    );

    run_fifo #(
        .MAX_CHUNK (MAX_CHUNK)
    ) i_run_fifo_a (
        .clock  (clock),
        .arst_n (arst_n),
        .wr     (load_a.sink),
        .rd     (run_a.source)
    );

    run_fifo #(
        .MAX_CHUNK (MAX_CHUNK)
    ) i_run_fifo_b (
        .clock  (clock),
        .arst_n (arst_n),
        .wr     (load_b.sink),
        .rd     (run_b.source)
    );

    merging_core #(
        .MAX_CHUNK (MAX_CHUNK)
    ) i_merging_core (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .size_a     (size_a),
        .size_b     (size_b),
        .run_a      (run_a.sink),
        .run_b      (run_b.sink),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready),
        .merge_done (merge_done)
    );

endmodule

`default_nettype wire

// ==== hw/merging_core.sv ====
// Output stage of the merge unit, which compares the two FIFO heads and streams out the smaller key
`default_nettype none
`timescale 1ns/1ns

module merging_core #(
    parameter int MAX_CHUNK = 32
) (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          start,
    input  wire [$clog2(MAX_CHUNK):0]    size_a,
    input  wire [$clog2(MAX_CHUNK):0]    size_b,
    run_stream_if.sink                   run_a,
    run_stream_if.sink                   run_b,
    output merge_pkg::data_t             out_data,
    output logic                         out_valid,
    output logic                         out_last,
    input  wire                          out_ready,
    output logic                         merge_done
);

    localparam int CNT_W = $clog2(MAX_CHUNK) + 1;

    merge_pkg::merge_state_e state;
    logic [CNT_W-1:0]        cnt_a;
    logic [CNT_W-1:0]        cnt_b;
    logic                    take_a;
    logic                    take_b;
    logic                    fire;
    logic                    a_ends;
    logic                    b_ends;

    // Equal keys go to A first, which keeps the merge stable
    always_comb begin
        take_a    = 1'b0;
        take_b    = 1'b0;
        out_valid = 1'b0;
        case (state)
            merge_pkg::merge_ab: begin
                out_valid = run_a.valid && run_b.valid;
                take_a    = (run_a.data <= run_b.data);
                take_b    = !take_a;
            end
            merge_pkg::drain_a: begin
                out_valid = run_a.valid;
                take_a    = 1'b1;
            end
            merge_pkg::drain_b: begin
                out_valid = run_b.valid;
                take_b    = 1'b1;
            end
            default: ;
        endcase
    end

    assign out_data = take_a ? run_a.data : run_b.data;
    assign fire     = out_valid && out_ready;

    // A head is popped only when the word actually leaves the core
    assign run_a.ready = fire && take_a;
    assign run_b.ready = fire && take_b;

    assign a_ends = (cnt_a + CNT_W'(1) == size_a);
    assign b_ends = (cnt_b + CNT_W'(1) == size_b);

    // The final word of a pair is always the last word of a drain phase
    assign out_last = out_valid &&
                      (((state == merge_pkg::drain_a) && a_ends) ||
                       ((state == merge_pkg::drain_b) && b_ends));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= merge_pkg::idle;
            cnt_a      <= '0;
            cnt_b      <= '0;
            merge_done <= 1'b0;
        end else begin
            merge_done <= 1'b0;
            if (fire && take_a) begin
                cnt_a <= cnt_a + CNT_W'(1);
            end
            if (fire && take_b) begin
                cnt_b <= cnt_b + CNT_W'(1);
            end
            case (state)
                merge_pkg::idle: begin
                    if (start) begin
                        state <= merge_pkg::merge_ab;
                        cnt_a <= '0;
                        cnt_b <= '0;
                    end
                end
                merge_pkg::merge_ab: begin
                    // Once one run runs out, the rest of the other is copied through
                    if (fire && take_a && a_ends) begin
                        state <= merge_pkg::drain_b;
                    end else if (fire && take_b && b_ends) begin
                        state <= merge_pkg::drain_a;
                    end
                end
                merge_pkg::drain_a, merge_pkg::drain_b: begin
                    if (fire && out_last) begin
                        state      <= merge_pkg::idle;
                        merge_done <= 1'b1;
                    end
                end
                default: state <= merge_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/run_fifo.sv ====
// Synchronous FIFO holding one sorted run, written by the loader and read by the merging core
`default_nettype none
`timescale 1ns/1ns

module run_fifo #(
    parameter int MAX_CHUNK = 32
) (
    input  wire          clock,
    input  wire          arst_n,
    run_stream_if.sink   wr,
    run_stream_if.source rd
);

    localparam int ADDR_W = $clog2(MAX_CHUNK);
    localparam int CNT_W  = $clog2(MAX_CHUNK) + 1;

    merge_pkg::data_t  mem_data [MAX_CHUNK];
    logic              mem_last [MAX_CHUNK];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign wr.ready = (count != CNT_W'(MAX_CHUNK));
    assign rd.valid = (count != '0);
    // Head is read straight from the array so a new word shows up one cycle after its write
    assign rd.data  = mem_data[rd_ptr];
    assign rd.last  = mem_last[rd_ptr];

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so the depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == ADDR_W'(MAX_CHUNK - 1)) ? '0 : wr_ptr + ADDR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ADDR_W'(MAX_CHUNK - 1)) ? '0 : rd_ptr + ADDR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/run_loader.sv ====
// Input stage of the merge unit, which splits the incoming stream into runs A and B and starts the merge
`default_nettype none
`timescale 1ns/1ns

module run_loader #(
    parameter int MAX_CHUNK = 32
) (
    input  wire                                      clock,
    input  wire                                      arst_n,
    input  wire merge_pkg::data_t                    in_data,
    input  wire                                      in_valid,
    input  wire                                      in_last,
    output logic                                     in_ready,
    run_stream_if.source                             load_a,
    run_stream_if.source                             load_b,
    input  wire                                      merge_done,
    output logic                                     start,
    output logic [$clog2(MAX_CHUNK):0]               size_a,
    output logic [$clog2(MAX_CHUNK):0]               size_b
);

    localparam int CNT_W = $clog2(MAX_CHUNK) + 1;

    merge_pkg::loader_state_e state;
    logic                     accept;

    // Both FIFOs see the same word, only the selected one gets valid
    assign load_a.data  = in_data;
    assign load_a.last  = in_last;
    assign load_a.valid = in_valid && (state == merge_pkg::load_a);
    assign load_b.data  = in_data;
    assign load_b.last  = in_last;
    assign load_b.valid = in_valid && (state == merge_pkg::load_b);

    always_comb begin
        case (state)
            merge_pkg::load_a: in_ready = load_a.ready;
            merge_pkg::load_b: in_ready = load_b.ready;
            default:           in_ready = 1'b0;
        endcase
    end

    assign accept = in_valid && in_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state  <= merge_pkg::load_a;
            start  <= 1'b0;
            size_a <= '0;
            size_b <= '0;
        end else begin
            // Start follows the cycle in which B's last word is taken
            start <= 1'b0;
            case (state)
                merge_pkg::load_a: begin
                    if (accept) begin
                        size_a <= size_a + CNT_W'(1);
                        if (in_last) begin
                            state <= merge_pkg::load_b;
                        end
                    end
                end
                merge_pkg::load_b: begin
                    if (accept) begin
                        size_b <= size_b + CNT_W'(1);
                        if (in_last) begin
                            state <= merge_pkg::wait_merge;
                            start <= 1'b1;
                        end
                    end
                end
                merge_pkg::wait_merge: begin
                    // Sizes stay put for the core until it reports the end of the merge
                    if (merge_done) begin
                        state  <= merge_pkg::load_a;
                        size_a <= '0;
                        size_b <= '0;
                    end
                end
                default: state <= merge_pkg::load_a;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/run_stream_if.sv ====
// Valid/ready word stream with a last marker, used between the loader, the run FIFOs and the core
`default_nettype none
`timescale 1ns/1ns

interface run_stream_if;

    merge_pkg::data_t data;
    logic             valid;
    logic             ready;
    logic             last;

    // The producing side holds data and last steady while valid is high and ready is low
    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== sim/merge_checker.sv ====
// Output monitor for the merge unit testbench, comparing every transferred word against the expected list
`default_nettype none
`timescale 1ns/1ns

module merge_checker (
    input wire                   clock,
    input wire                   arst_n,
    input wire                   in_ready,
    input wire merge_pkg::data_t out_data,
    input wire                   out_valid,
    input wire                   out_last,
    input wire                   out_ready,
    input wire                   merge_done
);

    string            test_name;
    merge_pkg::data_t exp_q[$];
    int               idx;
    int               err_count;
    int               done_count;

    task automatic begin_test(input string name);
        test_name  = name;
        exp_q.delete();
        idx        = 0;
        err_count  = 0;
        done_count = 0;
    endtask

    task automatic add_expected(input merge_pkg::data_t w);
        exp_q.push_back(w);
    endtask

    task automatic end_test(output int errs);
        if (idx != exp_q.size()) begin
            $display("Error in %s: received %0d words but expected %0d", test_name, idx,
                     exp_q.size());
            err_count++;
        end
        if (done_count != 1) begin
            $display("Error in %s: merge_done pulsed %0d times instead of once", test_name,
                     done_count);
            err_count++;
        end
        errs = err_count;
    endtask

    // Values seen here are the ones present just before the edge that moves the word
    always @(posedge clock) begin
        // Loading of the next pair stays blocked from the first output word until merge_done
        if (arst_n && idx > 0 && done_count == 0 && in_ready) begin
            $display("Error in %s: in_ready was high while the merge was still running",
                     test_name);
            err_count++;
        end
        if (arst_n && out_valid && out_ready) begin
            if (idx >= exp_q.size()) begin
                $display("Error in %s: extra output word %h after all expected words",
                         test_name, out_data);
                err_count++;
            end else begin
                if (out_data !== exp_q[idx]) begin
                    $display("Fail %s word %0d: expected %h, actual %h", test_name, idx,
                             exp_q[idx], out_data);
                    err_count++;
                end
                if (out_last !== (idx == exp_q.size() - 1)) begin
                    $display("Fail %s last flag of word %0d: expected %b, actual %b", test_name,
                             idx, (idx == exp_q.size() - 1), out_last);
                    err_count++;
                end
            end
            idx++;
        end
        if (arst_n && merge_done) begin
            done_count++;
            if (idx != exp_q.size()) begin
                $display("Error in %s: merge_done came after only %0d of %0d words", test_name,
                         idx, exp_q.size());
                err_count++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/merge_clock_gen.sv ====
// Testbench clock and reset source for the merge unit, with reset released on a falling edge
`default_nettype none
`timescale 1ns/1ns

module merge_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Release away from the rising edge so no flop sees reset and clock together
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/merge_testdata.txt ====
# Per test: name, size of run A and size of run B (decimal), back-pressure flag (0 or 1),
# then the run A words, the run B words and the expected merged words, all in hex
interleaved 4 4 0
1 4 9 a
2 3 8 14
1 2 3 4 8 9 a 14
a_runs_out_first 3 4 0
1 2 3
5 6 7 8
1 2 3 5 6 7 8
b_runs_out_first 3 2 0
10 20 30
1 2
1 2 10 20 30
equal_keys 3 3 0
5 5 7
5 7 9
5 5 5 7 7 9
single_words 1 1 0
ffff
0
0 ffff
full_runs 32 32 0
0 2 4 6 8 a c e 10 12 14 16 18 1a 1c 1e
20 22 24 26 28 2a 2c 2e 30 32 34 36 38 3a 3c 3e
1 3 5 7 9 b d f 11 13 15 17 19 1b 1d 1f
21 23 25 27 29 2b 2d 2f 31 33 35 37 39 3b 3d 3f
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
stalled_output 5 5 1
3 6 9 c f
1 6 a b 10
1 3 6 6 9 a b c f 10
full_runs_stalled 32 32 1
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
0 1 2 3 4 5 6 7 8 9 a b c d e f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f

// ==== sim/tb_merge_unit.sv ====
// Testbench top for the merge unit, which feeds run pairs from the test data file and reports results
`default_nettype none
`timescale 1ns/1ns

module tb_merge_unit;

    localparam int MAX_CHUNK = 32;
    localparam int TIMEOUT   = 2000;

    wire              clock;
    wire              arst_n;
    merge_pkg::data_t in_data;
    logic             in_valid;
    logic             in_last;
    logic             in_ready;
    merge_pkg::data_t out_data;
    logic             out_valid;
    logic             out_last;
    logic             out_ready;
    logic             merge_done;
    logic             back_pressure;

    merge_clock_gen #(
        .PERIOD       (40),
        .RESET_CYCLES (3)
    ) i_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    merge_unit #(
        .MAX_CHUNK (MAX_CHUNK)
    ) i_merge_unit (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready),
        .merge_done (merge_done)
    );

    merge_checker i_checker (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready),
        .merge_done (merge_done)
    );

    // Output side is always ready unless the test asks for random stalls
    always @(negedge clock) begin
        out_ready = back_pressure ? 1'($urandom & 32'd1) : 1'b1;
    end

    task automatic send_word(input merge_pkg::data_t w, input logic last_flag, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        @(negedge clock);
        in_data  = w;
        in_valid = 1'b1;
        in_last  = last_flag;
        while (!ok && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
            ok = in_ready;
        end
    endtask

    task automatic wait_done(output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        while (!ok && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
            ok = merge_done;
        end
    endtask

    initial begin
        string            tok;
        string            line;
        string            name;
        merge_pkg::data_t words[$];
        merge_pkg::data_t w;
        int               fd;
        int               code;
        int               na;
        int               nb;
        int               bp;
        int               errs;
        int               waited;
        int               pass_count;
        int               fail_count;
        logic             ok;
        logic             aborted;

        in_data       = '0;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        out_ready     = 1'b0;
        back_pressure <= 1'b0;
        pass_count    = 0;
        fail_count    = 0;
        aborted       = 1'b0;
        void'($urandom(32'h7a10));

        waited = 0;
        while (arst_n !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            $display("Reset was never released");
            aborted = 1'b1;
        end
        fd = $fopen("sim/merge_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file sim/merge_testdata.txt");
            aborted = 1'b1;
        end

        while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);
            end else begin
                name = tok;
                code = $fscanf(fd, "%d %d %d", na, nb, bp);
                words.delete();
                i_checker.begin_test(name);
                // Run A words come first, then run B, then the expected merge
                for (int i = 0; i < na + nb; i++) begin
                    code = $fscanf(fd, "%h", w);
                    words.push_back(w);
                end
                for (int i = 0; i < na + nb; i++) begin
                    code = $fscanf(fd, "%h", w);
                    i_checker.add_expected(w);
                end
                back_pressure <= (bp != 0);
                ok = 1'b1;
                for (int i = 0; i < na + nb && ok; i++) begin
                    send_word(words[i], (i == na - 1) || (i == na + nb - 1), ok);
                end
                @(negedge clock);
                in_valid = 1'b0;
                in_last  = 1'b0;
                if (ok) begin
                    wait_done(ok);
                    if (!ok) begin
                        $display("Timeout in test %s: merge_done never arrived", name);
                    end
                end else begin
                    $display("Timeout in test %s: the DUT stopped accepting input words", name);
                end
                if (ok) begin
                    @(negedge clock);
                    i_checker.end_test(errs);
                    if (errs == 0) begin
                        pass_count++;
                        $display("Test %s: passed", name);
                    end else begin
                        fail_count++;
                        $display("Test %s: failed with %0d errors", name, errs);
                    end
                end else begin
                    fail_count++;
                    aborted = 1'b1;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (!aborted && fail_count == 0 && pass_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/merge_pkg.sv
hw/run_stream_if.sv
hw/run_fifo.sv
hw/run_loader.sv
hw/merging_core.sv
hw/merge_unit.sv
sim/merge_clock_gen.sv
sim/merge_checker.sv
sim/tb_merge_unit.sv
